/* src/vga_fb_pkg.sv */
`default_nettype none

package vga_fb_pkg;

  // small test raster so that a whole frame simulates quickly
  localparam int h_visible = 8;
  localparam int h_front_porch = 2;
  localparam int h_sync_pulse = 3;
  localparam int h_back_porch = 3;
  localparam int h_whole_line = 16;

  localparam int v_visible = 6;
  localparam int v_front_porch = 1;
  localparam int v_sync_pulse = 2;
  localparam int v_back_porch = 1;
  localparam int v_whole_frame = 10;

  // sync pulse windows, measured from the start of the line or frame
  localparam int h_sync_start = h_visible + h_front_porch;
  localparam int h_sync_end = h_sync_start + h_sync_pulse;
  localparam int v_sync_start = v_visible + v_front_porch;
  localparam int v_sync_end = v_sync_start + v_sync_pulse;

  // one word per visible pixel
  localparam int fb_words = h_visible * v_visible;

  localparam int x_bits = $clog2(h_whole_line);
  localparam int y_bits = $clog2(v_whole_frame);
  localparam int addr_bits = $clog2(fb_words);
  localparam int data_bits = 16;
  localparam int color_bits = 4;
  localparam int meta_bits = 4;

  localparam int fifo_addr_bits = 3;
  localparam int fifo_depth = 1 << fifo_addr_bits;

  // read state machine encoding
  localparam logic state_idle = 1'b0;
  localparam logic state_reading = 1'b1;

  typedef struct packed {
    logic [x_bits-1:0] column;
    logic [y_bits-1:0] row;
  } raster_pos_t;

  typedef struct packed {
    logic visible;
    logic vsync;
    logic hsync;
  } pixel_ctx_t;

  typedef struct packed {
    logic [color_bits-1:0] red;
    logic [color_bits-1:0] grn;
    logic [color_bits-1:0] blu;
    logic [meta_bits-1:0]  meta;
  } fb_fields_t;

  // one frame-buffer word, seen as raw bits or as color and meta
  typedef union packed {
    logic [data_bits-1:0] raw;
    fb_fields_t           fields;
  } fb_word_t;

  typedef struct packed {
    logic [addr_bits-1:0] araddr;
  } fb_read_req_t;

  typedef struct packed {
    fb_word_t rdata;
  } fb_read_rsp_t;

  typedef struct packed {
    logic [addr_bits-1:0] addr;
    fb_word_t             data;
  } fb_write_t;

  typedef struct packed {
    logic     hsync;
    logic     vsync;
    fb_word_t color;
  } pixel_out_t;

endpackage

`default_nettype wire

/* src/vga_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_sync
  import vga_fb_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        step,
  output raster_pos_t pos,
  output pixel_ctx_t  ctx
);

  logic col_at_end;
  logic row_at_end;

  assign col_at_end = (pos.column == x_bits'(h_whole_line - 1));
  assign row_at_end = (pos.row == y_bits'(v_whole_frame - 1));

  // column runs fastest, row moves on each line wrap
  always_ff @(posedge clk) begin
    if (reset) begin
      pos.column <= '0;
      pos.row <= '0;
    end else if (step) begin
      if (col_at_end) begin
        pos.column <= '0;
        if (row_at_end) begin
          pos.row <= '0;
        end else begin
          pos.row <= pos.row + 1'b1;
        end
      end else begin
        pos.column <= pos.column + 1'b1;
      end
    end
  end

  logic h_active;
  logic v_active;
  logic h_in_sync;
  logic v_in_sync;

  assign h_active = (pos.column < h_visible);
  assign v_active = (pos.row < v_visible);

  // sync pulses are active high in this raster
  assign h_in_sync = (pos.column >= h_sync_start) && (pos.column < h_sync_end);
  assign v_in_sync = (pos.row >= v_sync_start) && (pos.row < v_sync_end);

  always_comb begin
    ctx.visible = h_active && v_active;
    ctx.hsync = h_in_sync;
    ctx.vsync = v_in_sync;
  end

  // the row counter never passes the last line of the frame
  a_pos_in_raster : assert property (
    @(posedge clk) disable iff (reset)
      pos.row < v_whole_frame
  );

endmodule

`default_nettype wire

/* src/pixel_context_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_context_fifo
  import vga_fb_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       push,
  input  pixel_ctx_t push_ctx,
  input  logic       pop,
  output pixel_ctx_t head,
  output logic       empty,
  output logic       full
);

  pixel_ctx_t mem [fifo_depth];

  // pointers carry one extra bit to tell full from empty
  logic [fifo_addr_bits:0] wr_ptr;
  logic [fifo_addr_bits:0] rd_ptr;

  logic do_push;
  logic do_pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[fifo_addr_bits] != rd_ptr[fifo_addr_bits]) &&
                (wr_ptr[fifo_addr_bits-1:0] == rd_ptr[fifo_addr_bits-1:0]);

  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (do_push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (do_pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[fifo_addr_bits-1:0]] <= push_ctx;
    end
  end

  // head is only meaningful while not empty
  assign head = mem[rd_ptr[fifo_addr_bits-1:0]];

  // occupancy is bounded by the reads in flight, so full is never reached by a push
  a_no_push_when_full : assert property (
    @(posedge clk) disable iff (reset) push |-> !full
  );

  a_no_pop_when_empty : assert property (
    @(posedge clk) disable iff (reset) pop |-> !empty
  );

endmodule

`default_nettype wire

/* src/fb_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_sram
  import vga_fb_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         fb_we,
  input  fb_write_t    fb_wr,
  input  logic         arvalid,
  input  fb_read_req_t read_req,
  output logic         arready,
  output logic         rvalid,
  output fb_read_rsp_t read_rsp,
  input  logic         rready
);

  logic [data_bits-1:0] mem [fb_words];

  logic read_accepted;

  assign read_accepted = arvalid && arready;

  // writes to addresses past the visible area are dropped
  always_ff @(posedge clk) begin
    if (fb_we && (fb_wr.addr < fb_words)) begin
      mem[fb_wr.addr] <= fb_wr.data.raw;
    end
  end

  // always ready once out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      arready <= 1'b0;
    end else begin
      arready <= 1'b1;
    end
  end

  // fixed one cycle read latency
  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= read_accepted;
    end
  end

  always_ff @(posedge clk) begin
    if (read_accepted) begin
      read_rsp.rdata.raw <= mem[read_req.araddr];
    end
  end

  // there is no response buffer, so the master must always take the data
  a_rready_on_rvalid : assert property (
    @(posedge clk) disable iff (reset) rvalid |-> rready
  );

endmodule

`default_nettype wire

/* src/vga_fb_pixel_stream.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_fb_pixel_stream
  import vga_fb_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         enable,
  output logic         step,
  input  raster_pos_t  pos,
  input  pixel_ctx_t   ctx,
  output logic         arvalid,
  output fb_read_req_t read_req,
  input  logic         arready,
  input  logic         rvalid,
  input  fb_read_rsp_t read_rsp,
  output logic         rready,
  output logic         push,
  output pixel_ctx_t   push_ctx,
  output logic         pop,
  input  pixel_ctx_t   head,
  input  logic         empty,
  output logic         valid,
  output pixel_out_t   pixel
);

  logic enable_q;
  logic step_q;
  logic [addr_bits-1:0] addr_q;
  pixel_ctx_t ctx_q;

  logic [addr_bits-1:0] pixel_addr;
  logic read_ok;
  logic read_start;
  logic read_accepted;
  logic read_done;

  logic state;
  logic next_state;

  // row-major word address of the current position
  assign pixel_addr = addr_bits'(pos.row * h_visible + pos.column);

  // blanking positions advance on enable alone, visible ones through a read
  assign step = read_start || (!ctx.visible && enable);

  always_ff @(posedge clk) begin
    if (reset) begin
      enable_q <= 1'b0;
      step_q <= 1'b0;
    end else begin
      enable_q <= enable;
      step_q <= step;
    end
  end

  // address and context stage one cycle behind the raster counters
  always_ff @(posedge clk) begin
    addr_q <= pixel_addr;
    ctx_q <= ctx;
  end

  // right after a step the staged context is the position just left
  assign read_ok = enable_q && ctx_q.visible && !step_q;

  assign read_accepted = arvalid && arready;
  assign read_done = rvalid && rready;

  always_comb begin
    next_state = state;
    read_start = 1'b0;
    case (state)
      state_idle: begin
        if (read_ok) begin
          next_state = state_reading;
          read_start = 1'b1;
        end
      end
      state_reading: begin
        // a new read may only go out once the last one is taken
        if (read_accepted) begin
          if (read_ok) begin
            read_start = 1'b1;
          end else begin
            next_state = state_idle;
          end
        end
      end
      default: begin
        next_state = state_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= state_idle;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      arvalid <= 1'b0;
    end else if (read_start) begin
      arvalid <= 1'b1;
    end else if (read_accepted) begin
      arvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (read_start) begin
      read_req.araddr <= addr_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rready <= 1'b1;
    end
  end

  // every step sends its context, paired with the staged address
  assign push = step_q;
  assign push_ctx = ctx_q;

  // blanking entries leave as soon as they reach the head
  assign pop = read_done || (!head.visible && !empty);

  // the output pixel holds until the next valid pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= 1'b0;
      pixel <= '0;
    end else begin
      valid <= pop;
      if (pop) begin
        pixel.hsync <= head.hsync;
        pixel.vsync <= head.vsync;
        if (head.visible) begin
          pixel.color <= read_rsp.rdata;
        end else begin
          pixel.color.raw <= '0;
        end
      end
    end
  end

  // read data always lands on its own visible context at the FIFO head
  a_rdata_meets_ctx : assert property (
    @(posedge clk) disable iff (reset) read_done |-> !empty && head.visible
  );

endmodule

`default_nettype wire

/* src/vga_fb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_fb_top
  import vga_fb_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       enable,
  input  logic       fb_we,
  input  fb_write_t  fb_wr,
  output logic       valid,
  output pixel_out_t pixel
);

  logic         step;
  raster_pos_t  pos;
  pixel_ctx_t   ctx;
  logic         arvalid;
  fb_read_req_t read_req;
  logic         arready;
  logic         rvalid;
  fb_read_rsp_t read_rsp;
  logic         rready;
  logic         push;
  pixel_ctx_t   push_ctx;
  logic         pop;
  pixel_ctx_t   head;
  logic         empty;

  vga_fb_pixel_stream stream_i (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .step     (step),
    .pos      (pos),
    .ctx      (ctx),
    .arvalid  (arvalid),
    .read_req (read_req),
    .arready  (arready),
    .rvalid   (rvalid),
    .read_rsp (read_rsp),
    .rready   (rready),
    .push     (push),
    .push_ctx (push_ctx),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .valid    (valid),
    .pixel    (pixel)
  );

  vga_sync sync_i (
    .clk   (clk),
    .reset (reset),
    .step  (step),
    .pos   (pos),
    .ctx   (ctx)
  );

  pixel_context_fifo fifo_i (
    .clk      (clk),
    .reset    (reset),
    .push     (push),
    .push_ctx (push_ctx),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .full     ()
  );

  fb_sram sram_i (
    .clk      (clk),
    .reset    (reset),
    .fb_we    (fb_we),
    .fb_wr    (fb_wr),
    .arvalid  (arvalid),
    .read_req (read_req),
    .arready  (arready),
    .rvalid   (rvalid),
    .read_rsp (read_rsp),
    .rready   (rready)
  );

endmodule

`default_nettype wire

/* test/vga_fb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_fb_tb
  import vga_fb_pkg::*;
();

  localparam int frame_pixels = h_whole_line * v_whole_frame;
  localparam int idle_limit = 500;
  localparam int drain_quiet = 20;
  localparam int drain_limit = 300;

  logic       clk;
  logic       reset;
  logic       enable;
  logic       fb_we;
  fb_write_t  fb_wr;
  logic       valid;
  pixel_out_t pixel;

  // model raster position and frame-buffer copy
  logic [data_bits-1:0] fb_model [fb_words];
  int model_col;
  int model_row;

  logic [31:0] lfsr_state;
  string test_name;
  int check_count;
  int error_count;
  int blank_count;
  int test_errors;
  bit timed_out;

  vga_fb_top dut_i (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .fb_we  (fb_we),
    .fb_wr  (fb_wr),
    .valid  (valid),
    .pixel  (pixel)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) begin
      s = s ^ 32'h80200003;
    end
    return s;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] random_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  function automatic pixel_out_t expected_pixel(int col, int row);
    pixel_out_t p;
    logic vis;
    vis = (col < h_visible) && (row < v_visible);
    p.hsync = (col >= h_visible + h_front_porch) &&
              (col < h_visible + h_front_porch + h_sync_pulse);
    p.vsync = (row >= v_visible + v_front_porch) &&
              (row < v_visible + v_front_porch + v_sync_pulse);
    p.color.raw = vis ? fb_model[row * h_visible + col] : '0;
    return p;
  endfunction

  task automatic check_pixel(string name, pixel_out_t exp, pixel_out_t act);
    check_count++;
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_word(string name, fb_word_t exp, fb_word_t act);
    check_count++;
    if (act.fields !== exp.fields) begin
      $display("Fail %s: expected rgbm %h/%h/%h/%h, actual %h/%h/%h/%h", name,
               exp.fields.red, exp.fields.grn, exp.fields.blu, exp.fields.meta,
               act.fields.red, act.fields.grn, act.fields.blu, act.fields.meta);
      error_count++;
    end
  endtask

  task automatic end_run();
    $display("checks %0d, errors %0d, blanking pixels %0d", check_count, error_count,
             blank_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  // compare the current output against the model, then move the model on
  task automatic check_next_pixel();
    pixel_out_t exp;
    fb_word_t exp_word;
    logic [data_bits-1:0] raw;
    exp = expected_pixel(model_col, model_row);
    raw = exp.color.raw;
    // red in the top nibble down to meta in the bottom one
    exp_word.fields.red = raw[15:12];
    exp_word.fields.grn = raw[11:8];
    exp_word.fields.blu = raw[7:4];
    exp_word.fields.meta = raw[3:0];
    if (!((model_col < h_visible) && (model_row < v_visible))) begin
      blank_count++;
    end
    check_pixel(test_name, exp, pixel);
    check_word(test_name, exp_word, pixel.color);
    model_col++;
    if (model_col == h_whole_line) begin
      model_col = 0;
      model_row = (model_row + 1) % v_whole_frame;
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errors = error_count;
  endtask

  task automatic finish_test(int pixels);
    $display("%s: %0d pixels, %0d errors", test_name, pixels, error_count - test_errors);
  endtask

  task automatic load_frame();
    fb_write_t wr;
    for (int a = 0; a < fb_words; a++) begin
      wr.addr = addr_bits'(a);
      wr.data.raw = data_bits'(random_bits(data_bits));
      fb_model[a] = wr.data.raw;
      @(posedge clk);
      fb_we <= 1'b1;
      fb_wr <= wr;
    end
    @(posedge clk);
    fb_we <= 1'b0;
  endtask

  task automatic run_pixels(int count, bit random_enable);
    int got;
    int idle;
    logic [31:0] bits;
    got = 0;
    idle = 0;
    while (!timed_out && got < count && idle < idle_limit) begin
      @(posedge clk);
      if (random_enable) begin
        bits = random_bits(1);
        enable <= bits[0];
      end else begin
        enable <= 1'b1;
      end
      @(negedge clk);
      if (valid) begin
        check_next_pixel();
        got++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (!timed_out && got < count) begin
      $display("%s: timed out waiting for a pixel, %0d of %0d seen", test_name, got, count);
      error_count++;
      timed_out = 1'b1;
    end
  endtask

  // pixels still in flight are checked while the stream runs dry
  task automatic drain_stream();
    int quiet;
    int cycles;
    quiet = 0;
    cycles = 0;
    @(posedge clk);
    enable <= 1'b0;
    while (!timed_out && quiet < drain_quiet && cycles < drain_limit) begin
      @(negedge clk);
      if (valid) begin
        check_next_pixel();
        quiet = 0;
      end else begin
        quiet++;
      end
      cycles++;
    end
    if (!timed_out && quiet < drain_quiet) begin
      $display("%s: stream kept producing pixels after enable went low", test_name);
      error_count++;
      timed_out = 1'b1;
    end
  endtask

  initial begin
    lfsr_state = 32'hcc2d2e71;
    model_col = 0;
    model_row = 0;
    check_count = 0;
    error_count = 0;
    blank_count = 0;
    timed_out = 1'b0;
    reset <= 1'b1;
    enable <= 1'b0;
    fb_we <= 1'b0;
    fb_wr <= '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    start_test("reset_idle");
    for (int i = 0; i < 50; i++) begin
      @(negedge clk);
      check_count++;
      if (valid) begin
        $display("%s: valid pulsed while enable was low", test_name);
        error_count++;
      end
    end
    finish_test(0);

    start_test("two_frames");
    load_frame();
    run_pixels(2 * frame_pixels, 1'b0);
    finish_test(2 * frame_pixels);

    start_test("blanking_sync");
    run_pixels(frame_pixels, 1'b0);
    finish_test(frame_pixels);

    start_test("random_enable");
    run_pixels(2 * frame_pixels, 1'b1);
    finish_test(2 * frame_pixels);

    start_test("reload");
    drain_stream();
    load_frame();
    run_pixels(2 * frame_pixels, 1'b0);
    finish_test(2 * frame_pixels);

    end_run();
  end

endmodule

`default_nettype wire

/* src.f */
src/vga_fb_pkg.sv
src/vga_sync.sv
src/pixel_context_fifo.sv
src/fb_sram.sv
src/vga_fb_pixel_stream.sv
src/vga_fb_top.sv
test/vga_fb_tb.sv

/* Bender.yml */
package:
  name: vga_fb

sources:
  - src/vga_fb_pkg.sv
  - src/vga_sync.sv
  - src/pixel_context_fifo.sv
  - src/fb_sram.sv
  - src/vga_fb_pixel_stream.sv
  - src/vga_fb_top.sv
  - target: test
    files:
      - test/vga_fb_tb.sv
